/* hw/icache_pkg.sv */
`default_nettype none

package icache_pkg;

  // fetch address and data widths
  parameter int ADDR_BITS = 64;
  parameter int WORD_BITS = 64;
  // only the low part of the address reaches the tag compare
  parameter int DECODE_BITS = 32;

  // line geometry, 32 bytes as four words
  parameter int WORDS_PER_LINE = 4;
  parameter int OFFSET_BITS = 5;
  parameter int WORD_IDX_BITS = 2;
  parameter int WORD_IDX_LSB = 3;
  parameter int LINE_BITS = WORD_BITS * WORDS_PER_LINE;

  typedef logic [ADDR_BITS-1:0] addr_t;
  typedef logic [WORD_BITS-1:0] word_t;
  typedef logic [WORD_IDX_BITS-1:0] word_idx_t;
  // word 0 sits in the lowest bits
  typedef logic [LINE_BITS-1:0] line_t;

  // register port
  parameter int CSR_ADDR_BITS = 2;
  parameter int CSR_DATA_BITS = 32;

  typedef logic [CSR_ADDR_BITS-1:0] csr_addr_t;
  typedef logic [CSR_DATA_BITS-1:0] csr_data_t;

  parameter csr_addr_t CSR_CTRL = 2'd0;
  parameter csr_addr_t CSR_HITS = 2'd1;
  parameter csr_addr_t CSR_MISSES = 2'd2;

endpackage

`default_nettype wire

/* hw/icache_arrays.sv */
`timescale 1ns/100ps
`default_nettype none

module icache_arrays
  import icache_pkg::*;
#(
  parameter int SET_BITS = 6
) (
  input  wire logic                                 clk,
  input  wire logic                                 rst_n,
  input  wire logic                                 rd_en,
  input  wire logic [SET_BITS-1:0]                  rd_set,
  input  wire logic                                 flush,
  input  wire logic                                 fill_en,
  input  wire logic                                 fill_way,
  input  wire logic [SET_BITS-1:0]                  fill_set,
  input  wire logic [DECODE_BITS-OFFSET_BITS-SET_BITS-1:0] fill_tag,
  input  wire line_t                                fill_line,
  output logic                                      way0_valid,
  output logic [DECODE_BITS-OFFSET_BITS-SET_BITS-1:0] way0_tag,
  output line_t                                     way0_line,
  output logic                                      way1_valid,
  output logic [DECODE_BITS-OFFSET_BITS-SET_BITS-1:0] way1_tag,
  output line_t                                     way1_line
);

  localparam int NUM_SETS = 1 << SET_BITS;
  localparam int TAG_W = DECODE_BITS - OFFSET_BITS - SET_BITS;

  // valid bits live in flops so flush clears them in one cycle
  logic [1:0][NUM_SETS-1:0] valid_q;

  logic [TAG_W-1:0] tag_mem [2][NUM_SETS];
  line_t            line_mem [2][NUM_SETS];

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      valid_q <= '0;
    end else if (flush) begin
      valid_q <= '0;
    end else if (fill_en) begin
      valid_q[fill_way][fill_set] <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (fill_en) begin
      tag_mem[fill_way][fill_set] <= fill_tag;
      line_mem[fill_way][fill_set] <= fill_line;
    end
  end

  // registered read of both ways
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      way0_valid <= 1'b0;
      way1_valid <= 1'b0;
    end else if (rd_en) begin
      way0_valid <= valid_q[0][rd_set];
      way1_valid <= valid_q[1][rd_set];
    end
  end

  always_ff @(posedge clk) begin
    if (rd_en) begin
      way0_tag <= tag_mem[0][rd_set];
      way0_line <= line_mem[0][rd_set];
      way1_tag <= tag_mem[1][rd_set];
      way1_line <= line_mem[1][rd_set];
    end
  end

  // flush only comes while the fetch port is idle
  a_no_fill_during_flush: assert property (
    @(posedge clk) disable iff (!rst_n)
    !(fill_en && flush)
  );

endmodule

`default_nettype wire

/* hw/icache_lru.sv */
`timescale 1ns/100ps
`default_nettype none

module icache_lru #(
  parameter int SET_BITS = 6
) (
  input  wire logic                clk,
  input  wire logic                rst_n,
  input  wire logic                flush,
  input  wire logic                touch_en,
  input  wire logic                touch_way,
  input  wire logic [SET_BITS-1:0] touch_set,
  input  wire logic                fill_en,
  input  wire logic                fill_way,
  input  wire logic [SET_BITS-1:0] fill_set,
  input  wire logic                rd_en,
  input  wire logic [SET_BITS-1:0] rd_set,
  output logic                     victim_way
);

  localparam int NUM_SETS = 1 << SET_BITS;

  // one bit per set naming the least recently used way
  logic [NUM_SETS-1:0] lru_q;

  always_ff @(posedge clk) begin
    if (!rst_n || flush) begin
      lru_q <= '0;
    end else if (fill_en) begin
      lru_q[fill_set] <= ~fill_way;
    end else if (touch_en) begin
      lru_q[touch_set] <= ~touch_way;
    end
  end

  // in step with the array read
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      victim_way <= 1'b0;
    end else if (rd_en) begin
      victim_way <= lru_q[rd_set];
    end
  end

endmodule

`default_nettype wire

/* hw/icache_refill.sv */
`timescale 1ns/100ps
`default_nettype none

module icache_refill
  import icache_pkg::*;
(
  input  wire logic  clk,
  input  wire logic  rst_n,
  input  wire logic  refill_start,
  input  wire addr_t refill_addr,
  input  wire word_t dram_data,
  input  wire logic  dram_val,
  output logic       dram_req,
  output addr_t      dram_req_addr,
  output logic       refill_done,
  output line_t      refill_line
);

  typedef enum logic [1:0] {
    rf_idle,
    rf_burst,
    rf_done
  } refill_state_t;

  refill_state_t state;
  word_idx_t     beat_cnt;
  logic          last_beat;

  assign last_beat = dram_val && (beat_cnt == word_idx_t'(WORDS_PER_LINE - 1));

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state <= rf_idle;
      dram_req <= 1'b0;
      beat_cnt <= '0;
    end else begin
      case (state)
        rf_idle: begin
          if (refill_start) begin
            state <= rf_burst;
            dram_req <= 1'b1;
            beat_cnt <= '0;
          end
        end
        rf_burst: begin
          if (dram_val) begin
            beat_cnt <= beat_cnt + 1'b1;
          end
          // request drops right after the last beat
          if (last_beat) begin
            state <= rf_done;
            dram_req <= 1'b0;
          end
        end
        rf_done: state <= rf_idle;
        default: state <= rf_idle;
      endcase
    end
  end

  assign refill_done = (state == rf_done);

  // line aligned, upper half of the address is not decoded
  always_ff @(posedge clk) begin
    if (state == rf_idle && refill_start) begin
      dram_req_addr <= {{(ADDR_BITS-DECODE_BITS){1'b0}},
                        refill_addr[DECODE_BITS-1:OFFSET_BITS], {OFFSET_BITS{1'b0}}};
    end
  end

  // beats arrive in ascending order, shift in from the top
  always_ff @(posedge clk) begin
    if (state == rf_burst && dram_val) begin
      refill_line <= {dram_data, refill_line[LINE_BITS-1:WORD_BITS]};
    end
  end

  a_val_needs_req: assert property (
    @(posedge clk) disable iff (!rst_n)
    dram_val |-> dram_req
  );

  a_start_when_free: assert property (
    @(posedge clk) disable iff (!rst_n)
    refill_start |-> (state != rf_burst)
  );

endmodule

`default_nettype wire

/* hw/icache_ctrl.sv */
`timescale 1ns/100ps
`default_nettype none

module icache_ctrl
  import icache_pkg::*;
#(
  parameter int SET_BITS = 6
) (
  input  wire logic                                 clk,
  input  wire logic                                 rst_n,
  input  wire logic                                 ins_req,
  input  wire addr_t                                cpu_addr,
  input  wire logic                                 enable,
  input  wire logic                                 way0_valid,
  input  wire logic [DECODE_BITS-OFFSET_BITS-SET_BITS-1:0] way0_tag,
  input  wire line_t                                way0_line,
  input  wire logic                                 way1_valid,
  input  wire logic [DECODE_BITS-OFFSET_BITS-SET_BITS-1:0] way1_tag,
  input  wire line_t                                way1_line,
  input  wire logic                                 victim_way,
  input  wire logic                                 refill_done,
  input  wire line_t                                refill_line,
  output logic                                      ins_ack,
  output word_t                                     instruction,
  output logic                                      rd_en,
  output logic [SET_BITS-1:0]                       rd_set,
  output logic                                      fill_en,
  output logic                                      fill_way,
  output logic [SET_BITS-1:0]                       fill_set,
  output logic [DECODE_BITS-OFFSET_BITS-SET_BITS-1:0] fill_tag,
  output line_t                                     fill_line,
  output logic                                      touch_en,
  output logic                                      touch_way,
  output logic [SET_BITS-1:0]                       touch_set,
  output logic                                      refill_start,
  output addr_t                                     refill_addr,
  output logic                                      hit_pulse,
  output logic                                      miss_pulse
);

  localparam int TAG_W = DECODE_BITS - OFFSET_BITS - SET_BITS;

  typedef enum logic [2:0] {
    st_idle,
    st_lookup,
    st_compare,
    st_refill,
    st_fill,
    st_ack
  } fetch_state_t;

  fetch_state_t       state;
  addr_t              addr_q;
  logic [TAG_W-1:0]   addr_tag;
  logic [SET_BITS-1:0] addr_set;
  word_idx_t          addr_word;
  logic               hit0;
  logic               hit1;
  logic               take_hit;

  function automatic word_t pick_word(line_t line, word_idx_t idx);
    pick_word = line[idx*WORD_BITS +: WORD_BITS];
  endfunction

  assign addr_set = addr_q[OFFSET_BITS +: SET_BITS];
  assign addr_tag = addr_q[DECODE_BITS-1:OFFSET_BITS+SET_BITS];
  assign addr_word = addr_q[WORD_IDX_LSB +: WORD_IDX_BITS];

  assign hit0 = way0_valid && (way0_tag == addr_tag);
  assign hit1 = way1_valid && (way1_tag == addr_tag);
  // bypass forces every fetch down the miss path
  assign take_hit = enable && (hit0 || hit1);

  assign rd_en = (state == st_lookup);
  assign rd_set = addr_set;
  assign touch_en = (state == st_compare) && take_hit;
  assign touch_way = hit1;
  assign touch_set = addr_set;
  assign refill_start = (state == st_compare) && !take_hit;
  assign refill_addr = addr_q;
  assign fill_en = (state == st_fill) && enable;
  assign fill_way = victim_way;
  assign fill_set = addr_set;
  assign fill_tag = addr_tag;
  assign fill_line = refill_line;
  assign ins_ack = (state == st_ack);

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state <= st_idle;
      hit_pulse <= 1'b0;
      miss_pulse <= 1'b0;
    end else begin
      hit_pulse <= 1'b0;
      miss_pulse <= 1'b0;
      case (state)
        st_idle: if (ins_req) state <= st_lookup;
        st_lookup: state <= st_compare;
        st_compare: begin
          if (take_hit) begin
            state <= st_ack;
            hit_pulse <= 1'b1;
          end else begin
            state <= st_refill;
            miss_pulse <= 1'b1;
          end
        end
        st_refill: if (refill_done) state <= st_fill;
        st_fill: state <= st_ack;
        // hold ack until the cpu lets go
        st_ack: if (!ins_req) state <= st_idle;
        default: state <= st_idle;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state == st_idle && ins_req) begin
      addr_q <= cpu_addr;
    end
    if (state == st_compare && take_hit) begin
      instruction <= pick_word(hit1 ? way1_line : way0_line, addr_word);
    end else if (state == st_fill) begin
      instruction <= pick_word(refill_line, addr_word);
    end
  end

  // a tag lives in at most one way of a set
  a_single_way_hit: assert property (
    @(posedge clk) disable iff (!rst_n)
    (state == st_compare) |-> !(hit0 && hit1)
  );

endmodule

`default_nettype wire

/* hw/icache_csr.sv */
`timescale 1ns/100ps
`default_nettype none

module icache_csr
  import icache_pkg::*;
(
  input  wire logic      clk,
  input  wire logic      rst_n,
  input  wire logic      csr_req,
  input  wire logic      csr_we,
  input  wire csr_addr_t csr_addr,
  input  wire csr_data_t csr_wdata,
  input  wire logic      hit_pulse,
  input  wire logic      miss_pulse,
  output logic           csr_ack,
  output csr_data_t      csr_rdata,
  output logic           enable,
  output logic           flush
);

  csr_data_t hit_cnt;
  csr_data_t miss_cnt;
  logic      access;

  // first cycle of a request, before ack goes up
  assign access = csr_req && !csr_ack;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      csr_ack <= 1'b0;
      enable <= 1'b1;
      flush <= 1'b0;
    end else begin
      csr_ack <= csr_req;
      flush <= 1'b0;
      if (access && csr_we && csr_addr == CSR_CTRL) begin
        enable <= csr_wdata[0];
        flush <= csr_wdata[1];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (access) begin
      case (csr_addr)
        CSR_CTRL: csr_rdata <= {{(CSR_DATA_BITS-1){1'b0}}, enable};
        CSR_HITS: csr_rdata <= hit_cnt;
        CSR_MISSES: csr_rdata <= miss_cnt;
        default: csr_rdata <= '0;
      endcase
    end
  end

  // saturating counters
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      hit_cnt <= '0;
      miss_cnt <= '0;
    end else begin
      if (hit_pulse && hit_cnt != '1) begin
        hit_cnt <= hit_cnt + 1'b1;
      end
      if (miss_pulse && miss_cnt != '1) begin
        miss_cnt <= miss_cnt + 1'b1;
      end
    end
  end

  a_hit_miss_exclusive: assert property (
    @(posedge clk) disable iff (!rst_n)
    !(hit_pulse && miss_pulse)
  );

endmodule

`default_nettype wire

/* hw/icache_top.sv */
`timescale 1ns/100ps
`default_nettype none

module icache_top
  import icache_pkg::*;
#(
  parameter int SET_BITS = 6
) (
  input  wire logic      clk,
  input  wire logic      rst_n,
  input  wire logic      ins_req,
  input  wire addr_t     cpu_addr,
  input  wire word_t     dram_data,
  input  wire logic      dram_val,
  input  wire logic      csr_req,
  input  wire logic      csr_we,
  input  wire csr_addr_t csr_addr,
  input  wire csr_data_t csr_wdata,
  output logic           ins_ack,
  output word_t          instruction,
  output logic           dram_req,
  output addr_t          dram_req_addr,
  output logic           csr_ack,
  output csr_data_t      csr_rdata
);

  localparam int TAG_W = DECODE_BITS - OFFSET_BITS - SET_BITS;

  logic                rd_en;
  logic [SET_BITS-1:0] rd_set;
  logic                fill_en;
  logic                fill_way;
  logic [SET_BITS-1:0] fill_set;
  logic [TAG_W-1:0]    fill_tag;
  line_t               fill_line;
  logic                touch_en;
  logic                touch_way;
  logic [SET_BITS-1:0] touch_set;
  logic                way0_valid;
  logic [TAG_W-1:0]    way0_tag;
  line_t               way0_line;
  logic                way1_valid;
  logic [TAG_W-1:0]    way1_tag;
  line_t               way1_line;
  logic                victim_way;
  logic                refill_start;
  addr_t               refill_addr;
  logic                refill_done;
  line_t               refill_line;
  logic                enable;
  logic                flush;
  logic                hit_pulse;
  logic                miss_pulse;

  icache_ctrl #(.SET_BITS(SET_BITS)) u_ctrl (.*);

  icache_arrays #(.SET_BITS(SET_BITS)) u_arrays (.*);

  icache_lru #(.SET_BITS(SET_BITS)) u_lru (.*);

  icache_refill u_refill (.*);

  icache_csr u_csr (.*);

endmodule

`default_nettype wire

/* verif/icache_dram_model.sv */
`timescale 1ns/100ps
`default_nettype none

module icache_dram_model
  import icache_pkg::*;
#(
  parameter word_t PATTERN = 64'h0
) (
  input  wire logic  clk,
  input  wire logic  rst_n,
  input  wire logic  dram_req,
  input  wire addr_t dram_req_addr,
  output word_t      dram_data,
  output logic       dram_val,
  output int         req_count,
  output addr_t      last_addr
);

  integer seed;
  int     beat;
  int     gap;
  logic   busy;

  initial begin
    seed = 85687;
    dram_data = '0;
    dram_val = 1'b0;
    req_count = 0;
    last_addr = '0;
    busy = 1'b0;
    beat = 0;
    gap = 0;
    forever begin
      @(posedge clk);
      #1;
      dram_val = 1'b0;
      if (!rst_n) begin
        busy = 1'b0;
      end else if (!busy) begin
        // new line request, latch it and pick the first gap
        if (dram_req) begin
          busy = 1'b1;
          beat = 0;
          gap = $random(seed) & 3;
          req_count = req_count + 1;
          last_addr = dram_req_addr;
        end
      end else if (gap > 0) begin
        gap = gap - 1;
      end else begin
        dram_val = 1'b1;
        dram_data = (dram_req_addr + addr_t'(8 * beat)) ^ PATTERN;
        beat = beat + 1;
        gap = $random(seed) & 3;
        // req drops on the edge that takes the last beat
        if (beat == WORDS_PER_LINE) begin
          busy = 1'b0;
        end
      end
    end
  end

endmodule

`default_nettype wire

/* verif/icache_tb.sv */
`timescale 1ns/100ps
`default_nettype none

module icache_tb
  import icache_pkg::*;
();

  localparam int SET_BITS = 6;
  localparam word_t DATA_PATTERN = 64'h5a3c_96e1_0f78_c3a5;
  localparam int ACK_TIMEOUT = 200;

  logic      clk;
  logic      rst_n;
  logic      ins_req;
  addr_t     cpu_addr;
  word_t     dram_data;
  logic      dram_val;
  logic      csr_req;
  logic      csr_we;
  csr_addr_t csr_addr;
  csr_data_t csr_wdata;
  logic      ins_ack;
  word_t     instruction;
  logic      dram_req;
  addr_t     dram_req_addr;
  logic      csr_ack;
  csr_data_t csr_rdata;
  int        req_count;
  addr_t     last_req_addr;

  int   errors;
  int   checks;
  int   hits;
  int   misses;
  logic aborted;

  icache_top #(.SET_BITS(SET_BITS)) u_icache_top (.*);

  icache_dram_model #(.PATTERN(DATA_PATTERN)) u_dram (
    .clk          (clk),
    .rst_n        (rst_n),
    .dram_req     (dram_req),
    .dram_req_addr(dram_req_addr),
    .dram_data    (dram_data),
    .dram_val     (dram_val),
    .req_count    (req_count),
    .last_addr    (last_req_addr)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // each beat is its byte address xor the pattern
  function automatic word_t expected_word(addr_t addr);
    expected_word = {addr[ADDR_BITS-1:3], 3'b000} ^ DATA_PATTERN;
  endfunction

  function automatic addr_t line_addr(addr_t addr);
    line_addr = {addr[ADDR_BITS-1:OFFSET_BITS], {OFFSET_BITS{1'b0}}};
  endfunction

  task automatic wait_ins_ack(input logic level);
    int cnt;
    cnt = 0;
    while (!aborted && ins_ack != level) begin
      @(posedge clk);
      #1;
      cnt++;
      if (cnt >= ACK_TIMEOUT) begin
        $display("timeout at %0t: ins_ack never went to %0b", $time, level);
        aborted = 1'b1;
      end
    end
  endtask

  task automatic wait_csr_ack(input logic level);
    int cnt;
    cnt = 0;
    while (!aborted && csr_ack != level) begin
      @(posedge clk);
      #1;
      cnt++;
      if (cnt >= ACK_TIMEOUT) begin
        $display("timeout at %0t: csr_ack never went to %0b", $time, level);
        aborted = 1'b1;
      end
    end
  endtask

  task automatic fetch(input addr_t addr, output word_t data, output int dram_reqs);
    int count_before;
    count_before = req_count;
    ins_req = 1'b1;
    cpu_addr = addr;
    wait_ins_ack(1'b1);
    data = instruction;
    dram_reqs = req_count - count_before;
    ins_req = 1'b0;
    wait_ins_ack(1'b0);
  endtask

  task automatic csr_access(input logic we, input csr_addr_t addr, input csr_data_t wdata,
                            output csr_data_t rdata);
    csr_req = 1'b1;
    csr_we = we;
    csr_addr = addr;
    csr_wdata = wdata;
    wait_csr_ack(1'b1);
    rdata = csr_rdata;
    csr_req = 1'b0;
    csr_we = 1'b0;
    wait_csr_ack(1'b0);
  endtask

  task automatic check_fetch(input addr_t addr, input logic expect_miss);
    word_t data;
    int    reqs;
    int    expect_reqs;
    fetch(addr, data, reqs);
    if (aborted) return;
    expect_reqs = expect_miss ? 1 : 0;
    if (expect_miss) begin
      misses++;
    end else begin
      hits++;
    end
    checks += 2;
    assert (data == expected_word(addr)) else begin
      $display("[FAIL] %0t: word at %h is %h, expected %h",
               $time, addr, data, expected_word(addr));
      errors++;
    end
    assert (reqs == expect_reqs) else begin
      $display("[FAIL] %0t: fetch of %h made %0d DRAM request(s), expected %0d",
               $time, addr, reqs, expect_reqs);
      errors++;
    end
    if (reqs > 0) begin
      checks++;
      assert (last_req_addr == line_addr(addr)) else begin
        $display("[FAIL] %0t: DRAM request at %h, expected %h",
                 $time, last_req_addr, line_addr(addr));
        errors++;
      end
    end
  endtask

  task automatic report_test(input string name, input int errors_before);
    if (aborted) begin
      $display("%s: stopped by a timeout", name);
    end else if (errors == errors_before) begin
      $display("%s: ok", name);
    end else begin
      $display("%s: %0d wrong value(s)", name, errors - errors_before);
    end
  endtask

  task automatic cold_miss_then_hit();
    int e0;
    e0 = errors;
    check_fetch(64'h1008, 1'b1);
    check_fetch(64'h1018, 1'b0);
    report_test("cold_miss_then_hit", e0);
  endtask

  task automatic select_each_word();
    int e0;
    e0 = errors;
    check_fetch(64'h3020, 1'b1);
    for (int i = 0; i < WORDS_PER_LINE; i++) begin
      check_fetch(64'h3020 + addr_t'(8 * i), 1'b0);
    end
    report_test("word_select", e0);
  endtask

  // three tags in set 2
  task automatic replace_lru_way();
    int e0;
    e0 = errors;
    check_fetch(64'h2040, 1'b1);
    check_fetch(64'h4040, 1'b1);
    check_fetch(64'h2040, 1'b0);
    check_fetch(64'h6040, 1'b1);
    check_fetch(64'h2040, 1'b0);
    check_fetch(64'h4040, 1'b1);
    report_test("lru_replacement", e0);
  endtask

  task automatic flush_all_lines();
    int        e0;
    csr_data_t rd;
    e0 = errors;
    check_fetch(64'h1008, 1'b0);
    csr_access(1'b1, CSR_CTRL, 32'h3, rd);
    check_fetch(64'h1008, 1'b1);
    check_fetch(64'h1008, 1'b0);
    report_test("flush", e0);
  endtask

  task automatic bypass_and_count();
    int        e0;
    csr_data_t rd;
    e0 = errors;
    csr_access(1'b1, CSR_CTRL, 32'h0, rd);
    check_fetch(64'h5460, 1'b1);
    check_fetch(64'h5460, 1'b1);
    csr_access(1'b1, CSR_CTRL, 32'h1, rd);
    // nothing was allocated while bypassed
    check_fetch(64'h5460, 1'b1);
    check_fetch(64'h5460, 1'b0);
    csr_access(1'b0, CSR_HITS, 32'h0, rd);
    checks++;
    assert (aborted || rd == csr_data_t'(hits)) else begin
      $display("[FAIL] %0t: hit count %0d, expected %0d", $time, rd, hits);
      errors++;
    end
    csr_access(1'b0, CSR_MISSES, 32'h0, rd);
    checks++;
    assert (aborted || rd == csr_data_t'(misses)) else begin
      $display("[FAIL] %0t: miss count %0d, expected %0d", $time, rd, misses);
      errors++;
    end
    report_test("bypass_counters", e0);
  endtask

  initial begin
    rst_n = 1'b0;
    ins_req = 1'b0;
    cpu_addr = '0;
    csr_req = 1'b0;
    csr_we = 1'b0;
    csr_addr = '0;
    csr_wdata = '0;
    errors = 0;
    checks = 0;
    hits = 0;
    misses = 0;
    aborted = 1'b0;
    repeat (5) @(posedge clk);
    #1;
    rst_n = 1'b1;

    cold_miss_then_hit();
    select_each_word();
    replace_lru_way();
    flush_all_lines();
    bypass_and_count();

    $display("checks: %0d, errors: %0d, timed out: %0b", checks, errors, aborted);
    if (errors == 0 && !aborted) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* icache_top.f */
hw/icache_pkg.sv
hw/icache_arrays.sv
hw/icache_lru.sv
hw/icache_refill.sv
hw/icache_ctrl.sv
hw/icache_csr.sv
hw/icache_top.sv
verif/icache_dram_model.sv
verif/icache_tb.sv

/* run_sim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f icache_top.f --top-module icache_tb -o icache_sim

./obj_dir/icache_sim | tee sim.log

if grep -q "tests failed" sim.log; then
  echo "simulation reported failures, see sim.log"
  exit 1
fi
if ! grep -q "all tests passed" sim.log; then
  echo "simulation ended without a result, see sim.log"
  exit 1
fi
echo "simulation clean"
